/* all.f */
src/dma_int_pkg.sv
src/dma_ctrl_regs.sv
src/dma_xfer_engine.sv
src/int_manager.sv
src/pcie_dma_core.sv
testbench/tb_clkgen.sv
testbench/tb_pcie_dma_core.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the DMA interrupt testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_pcie_dma_core -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "All tests passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see sim.log"
    exit 1
fi

/* testbench/tb_pcie_dma_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pcie_dma_core;

    logic        clk;
    logic        arst_n;
    logic        reg_wr;
    logic [2:0]  reg_addr;
    logic [31:0] reg_wdata;
    logic [31:0] reg_rdata;
    logic        rd_ack;
    logic        wr_ack;
    logic        cfg_n;
    logic        cfg_assert_n;
    logic        rdy_n;

    int          check_errs  = 0;
    int          assert_errs = 0;
    logic [31:0] ack_seed    = 32'd7;
    logic [31:0] ep_seed     = 32'd7;
    logic [31:0] ctrl_base   = 32'h0;
    logic [31:0] exp_cnt     = 32'h0;
    logic [31:0] rdata;
    logic        ep_hold     = 1'b0;
    logic        timing_on   = 1'b0;
    logic        quiet_on    = 1'b0;

    tb_clkgen u_clkgen (.clk(clk), .arst_n_o(arst_n));

    pcie_dma_core UUT (
        .clk                      (clk),
        .arst_n_i                 (arst_n),
        .reg_wr_i                 (reg_wr),
        .reg_addr_i               (reg_addr),
        .reg_wdata_i              (reg_wdata),
        .reg_rdata_o              (reg_rdata),
        .rd_ack_i                 (rd_ack),
        .wr_ack_i                 (wr_ack),
        .cfg_interrupt_n_o        (cfg_n),
        .cfg_interrupt_assert_n_o (cfg_assert_n),
        .cfg_interrupt_rdy_n_i    (rdy_n)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            check_errs++;
        end
    endtask

    task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr    <= 1'b0;
    endtask

    task automatic read_reg(input logic [2:0] addr, output logic [31:0] data);
        @(posedge clk);
        reg_addr <= addr;
        @(negedge clk);
        data = reg_rdata;
    endtask

    // start one transfer and give exactly len random acks.
    task automatic run_xfer(input bit is_wr, input int len);
        int n;
        int busy_bit;
        int done_bit;
        n        = 0;
        busy_bit = is_wr ? dma_int_pkg::STATUS_WR_BUSY : dma_int_pkg::STATUS_RD_BUSY;
        done_bit = is_wr ? dma_int_pkg::STATUS_WR_DONE : dma_int_pkg::STATUS_RD_DONE;
        write_reg(is_wr ? dma_int_pkg::ADDR_WR_LEN : dma_int_pkg::ADDR_RD_LEN, len);
        write_reg(dma_int_pkg::ADDR_CTRL, ctrl_base | (32'd1 << (is_wr ?
            dma_int_pkg::CTRL_WR_START : dma_int_pkg::CTRL_RD_START)));
        @(posedge clk);
        reg_addr <= dma_int_pkg::ADDR_STATUS;
        while (n < len) begin
            @(posedge clk);
            ack_seed = xorshift(ack_seed);
            if (is_wr) wr_ack <= ack_seed[0];
            else       rd_ack <= ack_seed[0];
            n += ack_seed[0];
            @(negedge clk);
            check("xfer_busy", 32'd1, reg_rdata[busy_bit]);
        end
        @(posedge clk);
        @(negedge clk);
        check("xfer_done", 32'd1, reg_rdata[done_bit]);
        check("xfer_idle", 32'd0, reg_rdata[busy_bit]);
        // the last ack lingers one cycle past the end.
        @(posedge clk);
        rd_ack <= 1'b0;
        wr_ack <= 1'b0;
    endtask

    task automatic wait_int_done;
        while (cfg_n) @(posedge clk);
        while (!cfg_n) @(posedge clk);
    endtask

    //////////////////////////////
    // endpoint model.
    //////////////////////////////

    always begin
        @(posedge clk);
        if (!cfg_n && rdy_n) begin
            ep_seed = xorshift(ep_seed);
            repeat (ep_seed % 4) @(posedge clk);
            while (ep_hold) @(posedge clk);
            rdy_n <= 1'b0;
            @(posedge clk);
            rdy_n <= 1'b1;
        end
    end

    //////////////////////////////
    // assertions.
    //////////////////////////////

    a_lines_eq: assert property (@(posedge clk) disable iff (!arst_n) cfg_n == cfg_assert_n)
        else begin
            $display("** Error lines_equal: expected %b, actual %b",
                $sampled(cfg_n), $sampled(cfg_assert_n));
            assert_errs++;
        end

    a_release: assert property (@(posedge clk) disable iff (!arst_n)
        (!cfg_n && !rdy_n) |=> cfg_n)
        else begin
            $display("** Error int_release: expected %b, actual %b", 1'b1, $sampled(cfg_n));
            assert_errs++;
        end

    // lines hold until rdy_n is seen low.
    a_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (!cfg_n && rdy_n && UUT.en) |=> !cfg_n)
        else begin
            $display("** Error int_hold: expected %b, actual %b", 1'b0, $sampled(cfg_n));
            assert_errs++;
        end

    a_int_timing: assert property (@(posedge clk) disable iff (!arst_n)
        (timing_on && $rose(UUT.rd_done)) |-> ##2 !cfg_n)
        else begin
            $display("** Error int_timing: expected %b, actual %b", 1'b0, $sampled(cfg_n));
            assert_errs++;
        end

    a_quiet: assert property (@(posedge clk) disable iff (!arst_n) quiet_on |-> cfg_n)
        else begin
            $display("** Error int_masked: expected %b, actual %b", 1'b1, $sampled(cfg_n));
            assert_errs++;
        end

    // watchdog at twice the worst-case sum of test lengths.
    initial begin
        int worst_cycles;
        worst_cycles = 30 + 80 + 60 + 100 + 60 + 40;
        repeat (2 * worst_cycles + 5) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", 2 * worst_cycles);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        reg_wr    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        rd_ack    = 1'b0;
        wr_ack    = 1'b0;
        rdy_n     = 1'b1;
        wait (arst_n);
        // register readback with start ignored while en is clear.
        write_reg(dma_int_pkg::ADDR_RD_LEN, 32'h0000_1234);
        write_reg(dma_int_pkg::ADDR_WR_LEN, 32'h0000_beef);
        write_reg(dma_int_pkg::ADDR_CTRL, 32'h0000_003e);
        read_reg(dma_int_pkg::ADDR_RD_LEN, rdata);
        check("readback_rd_len", 32'h1234, rdata);
        read_reg(dma_int_pkg::ADDR_WR_LEN, rdata);
        check("readback_wr_len", 32'hbeef, rdata);
        read_reg(dma_int_pkg::ADDR_CTRL, rdata);
        check("readback_ctrl", 32'h000e, rdata);
        read_reg(3'd5, rdata);
        check("readback_unknown", 32'h0, rdata);
        // transfer completion.
        ctrl_base = 32'h1;
        run_xfer(1'b0, 5);
        run_xfer(1'b1, 3);
        run_xfer(1'b0, 0);
        // unmasked interrupt with timing check.
        ctrl_base = 32'h3;
        timing_on = 1'b1;
        run_xfer(1'b0, 4);
        exp_cnt++;
        wait_int_done();
        timing_on = 1'b0;
        read_reg(dma_int_pkg::ADDR_INT_CNT, rdata);
        check("int_count", exp_cnt, rdata);
        // read masked while write still interrupts.
        ctrl_base = 32'h7;
        quiet_on  = 1'b1;
        run_xfer(1'b0, 3);
        repeat (4) @(posedge clk);
        quiet_on  = 1'b0;
        run_xfer(1'b1, 2);
        exp_cnt++;
        wait_int_done();
        read_reg(dma_int_pkg::ADDR_INT_CNT, rdata);
        check("mask_count", exp_cnt, rdata);
        // int_en clear.
        ctrl_base = 32'h1;
        quiet_on  = 1'b1;
        run_xfer(1'b0, 2);
        run_xfer(1'b1, 2);
        repeat (4) @(posedge clk);
        quiet_on  = 1'b0;
        read_reg(dma_int_pkg::ADDR_INT_CNT, rdata);
        check("disable_count", exp_cnt, rdata);
        // write completes while the read interrupt is pending.
        ctrl_base = 32'h3;
        ep_hold   = 1'b1;
        run_xfer(1'b0, 2);
        while (cfg_n) @(posedge clk);
        run_xfer(1'b1, 1);
        exp_cnt  += 2;
        ep_hold   = 1'b0;
        while (!cfg_n) @(posedge clk);
        wait_int_done();
        read_reg(dma_int_pkg::ADDR_INT_CNT, rdata);
        check("overlap_count", exp_cnt, rdata);
        // enable clear while pending and busy.
        ep_hold = 1'b1;
        run_xfer(1'b1, 1);
        while (cfg_n) @(posedge clk);
        write_reg(dma_int_pkg::ADDR_RD_LEN, 32'd3);
        write_reg(dma_int_pkg::ADDR_CTRL, 32'h13);
        write_reg(dma_int_pkg::ADDR_CTRL, 32'h0);
        read_reg(dma_int_pkg::ADDR_INT_CNT, rdata);
        check("en_clear_count", 32'h0, rdata);
        read_reg(dma_int_pkg::ADDR_STATUS, rdata);
        check("en_clear_status", 32'h0, rdata);
        check("en_clear_lines", 32'h1, cfg_n);
        ep_hold = 1'b0;
        repeat (3) @(posedge clk);
        $display("check errors: %0d, assertion errors: %0d", check_errs, assert_errs);
        if (check_errs == 0 && assert_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic arst_n_o
);

    initial begin
        clk      = 1'b0;
        arst_n_o = 1'b0;
        repeat (5) @(posedge clk);
        arst_n_o <= 1'b1;
    end

    // 4 ns period.
    always #2 clk = ~clk;

endmodule

`default_nettype wire

/* src/pcie_dma_core.sv */
`timescale 1ns/1ps
`default_nettype none

module pcie_dma_core (
    input  wire                                clk,
    input  wire                                arst_n_i,
    input  wire                                reg_wr_i,
    input  wire  [dma_int_pkg::ADDR_W-1:0]     reg_addr_i,
    input  wire  [dma_int_pkg::DATA_W-1:0]     reg_wdata_i,
    output logic [dma_int_pkg::DATA_W-1:0]     reg_rdata_o,
    input  wire                                rd_ack_i,
    input  wire                                wr_ack_i,
    output logic                               cfg_interrupt_n_o,
    output logic                               cfg_interrupt_assert_n_o,
    input  wire                                cfg_interrupt_rdy_n_i
);

    logic                              en;
    logic                              int_en;
    logic                              rd_msk;
    logic                              wr_msk;
    logic [dma_int_pkg::LEN_W-1:0]     rd_len;
    logic [dma_int_pkg::LEN_W-1:0]     wr_len;
    logic                              rd_start;
    logic                              wr_start;
    logic                              rd_busy;
    logic                              wr_busy;
    logic                              rd_done;
    logic                              wr_done;
    logic [dma_int_pkg::DATA_W-1:0]    int_cnt;

    dma_ctrl_regs u_regs (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .reg_wr_i    (reg_wr_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_rdata_o (reg_rdata_o),
        .rd_busy_i   (rd_busy),
        .wr_busy_i   (wr_busy),
        .rd_done_i   (rd_done),
        .wr_done_i   (wr_done),
        .int_cnt_i   (int_cnt),
        .en_o        (en),
        .int_en_o    (int_en),
        .rd_msk_o    (rd_msk),
        .wr_msk_o    (wr_msk),
        .rd_len_o    (rd_len),
        .wr_len_o    (wr_len),
        .rd_start_o  (rd_start),
        .wr_start_o  (wr_start)
    );

    // one engine per direction.
    dma_xfer_engine #(.LEN_W_P(dma_int_pkg::LEN_W)) u_rd_engine (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .en_i     (en),
        .start_i  (rd_start),
        .len_i    (rd_len),
        .ack_i    (rd_ack_i),
        .busy_o   (rd_busy),
        .done_o   (rd_done)
    );

    dma_xfer_engine #(.LEN_W_P(dma_int_pkg::LEN_W)) u_wr_engine (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .en_i     (en),
        .start_i  (wr_start),
        .len_i    (wr_len),
        .ack_i    (wr_ack_i),
        .busy_o   (wr_busy),
        .done_o   (wr_done)
    );

    int_manager u_int_manager (
        .clk                      (clk),
        .arst_n_i                 (arst_n_i),
        .en_i                     (en),
        .int_en_i                 (int_en),
        .rd_msk_i                 (rd_msk),
        .wr_msk_i                 (wr_msk),
        .rd_done_i                (rd_done),
        .wr_done_i                (wr_done),
        .int_cnt_o                (int_cnt),
        .cfg_interrupt_n_o        (cfg_interrupt_n_o),
        .cfg_interrupt_assert_n_o (cfg_interrupt_assert_n_o),
        .cfg_interrupt_rdy_n_i    (cfg_interrupt_rdy_n_i)
    );

endmodule

`default_nettype wire

/* src/int_manager.sv */
`timescale 1ns/1ps
`default_nettype none

module int_manager (
    input  wire                                clk,
    input  wire                                arst_n_i,
    input  wire                                en_i,
    input  wire                                int_en_i,
    input  wire                                rd_msk_i,
    input  wire                                wr_msk_i,
    input  wire                                rd_done_i,
    input  wire                                wr_done_i,
    output logic [dma_int_pkg::DATA_W-1:0]     int_cnt_o,
    output logic                               cfg_interrupt_n_o,
    output logic                               cfg_interrupt_assert_n_o,
    input  wire                                cfg_interrupt_rdy_n_i
);

    logic       rd_done_q;
    logic       wr_done_q;
    logic       rd_pend_q;
    logic       wr_pend_q;
    logic [1:0] state_q;
    logic       rd_rise;
    logic       wr_rise;
    logic       take;

    assign rd_rise = rd_done_i && !rd_done_q && !rd_msk_i;
    assign wr_rise = wr_done_i && !wr_done_q && !wr_msk_i;

    // flags are consumed when the interrupt goes out.
    assign take = (state_q == dma_int_pkg::INT_IDLE) && (rd_pend_q || wr_pend_q);

    //////////////////////////////
    // edge detect and pending.
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_done_q <= 1'b0;
            wr_done_q <= 1'b0;
            rd_pend_q <= 1'b0;
            wr_pend_q <= 1'b0;
        end else if (!en_i) begin
            rd_done_q <= 1'b0;
            wr_done_q <= 1'b0;
            rd_pend_q <= 1'b0;
            wr_pend_q <= 1'b0;
        end else begin
            rd_done_q <= rd_done_i;
            wr_done_q <= wr_done_i;
            if (!int_en_i) begin
                rd_pend_q <= 1'b0;
                wr_pend_q <= 1'b0;
            end else begin
                // a new edge wins over the clear.
                rd_pend_q <= (rd_pend_q && !take) || rd_rise;
                wr_pend_q <= (wr_pend_q && !take) || wr_rise;
            end
        end
    end

    //////////////////////////////
    // cfg_interrupt handshake.
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cfg_interrupt_n_o        <= 1'b1;
            cfg_interrupt_assert_n_o <= 1'b1;
            int_cnt_o                <= '0;
            state_q                  <= dma_int_pkg::INT_IDLE;
        end else if (!en_i) begin
            cfg_interrupt_n_o        <= 1'b1;
            cfg_interrupt_assert_n_o <= 1'b1;
            int_cnt_o                <= '0;
            state_q                  <= dma_int_pkg::INT_IDLE;
        end else begin
            case (state_q)
                dma_int_pkg::INT_IDLE: begin
                    if (take) begin
                        cfg_interrupt_n_o        <= 1'b0;
                        cfg_interrupt_assert_n_o <= 1'b0;
                        int_cnt_o                <= int_cnt_o + 1'b1;
                        state_q                  <= dma_int_pkg::INT_PENDING;
                    end
                end
                dma_int_pkg::INT_PENDING: begin
                    // hold until the endpoint takes it.
                    if (!cfg_interrupt_rdy_n_i) begin
                        cfg_interrupt_n_o        <= 1'b1;
                        cfg_interrupt_assert_n_o <= 1'b1;
                        state_q                  <= dma_int_pkg::INT_IDLE;
                    end
                end
                default: state_q <= dma_int_pkg::INT_IDLE;
            endcase
        end
    end

    a_lines_equal: assert property (@(posedge clk) disable iff (!arst_n_i)
        cfg_interrupt_n_o == cfg_interrupt_assert_n_o)
        else $error("interrupt lines differ");

    // count moves on entry to pending, or back to zero on disable.
    a_cnt_on_entry: assert property (@(posedge clk) disable iff (!arst_n_i)
        (int_cnt_o != $past(int_cnt_o))
        |-> ((state_q == dma_int_pkg::INT_PENDING && $past(state_q) == dma_int_pkg::INT_IDLE)
             || int_cnt_o == '0))
        else $error("interrupt count changed outside pending entry");

endmodule

`default_nettype wire

/* src/dma_xfer_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_xfer_engine #(
    parameter int LEN_W_P = dma_int_pkg::LEN_W
) (
    input  wire                clk,
    input  wire                arst_n_i,
    input  wire                en_i,
    input  wire                start_i,
    input  wire  [LEN_W_P-1:0] len_i,
    input  wire                ack_i,
    output logic               busy_o,
    output logic               done_o
);

    logic [LEN_W_P-1:0] remain_q;
    logic               last_ack;

    // final acknowledge of the transfer.
    assign last_ack = busy_o && ack_i && (remain_q == LEN_W_P'(1));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            remain_q <= '0;
            busy_o   <= 1'b0;
            done_o   <= 1'b0;
        end else if (!en_i) begin
            remain_q <= '0;
            busy_o   <= 1'b0;
            done_o   <= 1'b0;
        end else if (start_i) begin
            // also restarts a running transfer.
            remain_q <= len_i;
            busy_o   <= (len_i != '0);
            done_o   <= (len_i == '0);
        end else if (busy_o && ack_i) begin
            remain_q <= remain_q - LEN_W_P'(1);
            if (last_ack) begin
                busy_o <= 1'b0;
                done_o <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // checks.
    //////////////////////////////

    a_busy_done_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(busy_o && done_o))
        else $error("busy and done high together");

    // a stray acknowledge must not move the count or the done level.
    a_idle_ack: assert property (@(posedge clk) disable iff (!arst_n_i)
        (en_i && !start_i && !busy_o && ack_i)
        |=> ($stable(remain_q) && $stable(done_o) && !busy_o))
        else $error("ack outside busy changed engine state");

endmodule

`default_nettype wire

/* src/dma_ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl_regs (
    input  wire                                clk,
    input  wire                                arst_n_i,
    input  wire                                reg_wr_i,
    input  wire  [dma_int_pkg::ADDR_W-1:0]     reg_addr_i,
    input  wire  [dma_int_pkg::DATA_W-1:0]     reg_wdata_i,
    output logic [dma_int_pkg::DATA_W-1:0]     reg_rdata_o,
    input  wire                                rd_busy_i,
    input  wire                                wr_busy_i,
    input  wire                                rd_done_i,
    input  wire                                wr_done_i,
    input  wire  [dma_int_pkg::DATA_W-1:0]     int_cnt_i,
    output logic                               en_o,
    output logic                               int_en_o,
    output logic                               rd_msk_o,
    output logic                               wr_msk_o,
    output logic [dma_int_pkg::LEN_W-1:0]      rd_len_o,
    output logic [dma_int_pkg::LEN_W-1:0]      wr_len_o,
    output logic                               rd_start_o,
    output logic                               wr_start_o
);

    logic ctrl_wr;
    logic start_ok;

    assign ctrl_wr  = reg_wr_i && (reg_addr_i == dma_int_pkg::ADDR_CTRL);
    // en may arrive in the same word as the start bit.
    assign start_ok = reg_wdata_i[dma_int_pkg::CTRL_EN] || en_o;

    //////////////////////////////
    // write side.
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            en_o       <= 1'b0;
            int_en_o   <= 1'b0;
            rd_msk_o   <= 1'b0;
            wr_msk_o   <= 1'b0;
            rd_len_o   <= '0;
            wr_len_o   <= '0;
            rd_start_o <= 1'b0;
            wr_start_o <= 1'b0;
        end else begin
            rd_start_o <= ctrl_wr && start_ok && reg_wdata_i[dma_int_pkg::CTRL_RD_START];
            wr_start_o <= ctrl_wr && start_ok && reg_wdata_i[dma_int_pkg::CTRL_WR_START];
            if (ctrl_wr) begin
                en_o     <= reg_wdata_i[dma_int_pkg::CTRL_EN];
                int_en_o <= reg_wdata_i[dma_int_pkg::CTRL_INT_EN];
                rd_msk_o <= reg_wdata_i[dma_int_pkg::CTRL_RD_MSK];
                wr_msk_o <= reg_wdata_i[dma_int_pkg::CTRL_WR_MSK];
            end
            if (reg_wr_i && (reg_addr_i == dma_int_pkg::ADDR_RD_LEN)) begin
                rd_len_o <= reg_wdata_i[dma_int_pkg::LEN_W-1:0];
            end
            if (reg_wr_i && (reg_addr_i == dma_int_pkg::ADDR_WR_LEN)) begin
                wr_len_o <= reg_wdata_i[dma_int_pkg::LEN_W-1:0];
            end
        end
    end

    //////////////////////////////
    // read side.
    //////////////////////////////

    always_comb begin
        reg_rdata_o = '0;
        case (reg_addr_i)
            dma_int_pkg::ADDR_CTRL: begin
                reg_rdata_o[dma_int_pkg::CTRL_EN]     = en_o;
                reg_rdata_o[dma_int_pkg::CTRL_INT_EN] = int_en_o;
                reg_rdata_o[dma_int_pkg::CTRL_RD_MSK] = rd_msk_o;
                reg_rdata_o[dma_int_pkg::CTRL_WR_MSK] = wr_msk_o;
            end
            dma_int_pkg::ADDR_RD_LEN:  reg_rdata_o[dma_int_pkg::LEN_W-1:0] = rd_len_o;
            dma_int_pkg::ADDR_WR_LEN:  reg_rdata_o[dma_int_pkg::LEN_W-1:0] = wr_len_o;
            dma_int_pkg::ADDR_STATUS: begin
                reg_rdata_o[dma_int_pkg::STATUS_RD_DONE] = rd_done_i;
                reg_rdata_o[dma_int_pkg::STATUS_WR_DONE] = wr_done_i;
                reg_rdata_o[dma_int_pkg::STATUS_RD_BUSY] = rd_busy_i;
                reg_rdata_o[dma_int_pkg::STATUS_WR_BUSY] = wr_busy_i;
            end
            dma_int_pkg::ADDR_INT_CNT: reg_rdata_o = int_cnt_i;
            default:                   reg_rdata_o = '0;
        endcase
    end

    // start strobes are single cycle.
    a_rd_start_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        rd_start_o |=> !rd_start_o)
        else $error("rd_start held for two cycles");

    a_wr_start_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        wr_start_o |=> !wr_start_o)
        else $error("wr_start held for two cycles");

endmodule

`default_nettype wire

/* src/dma_int_pkg.sv */
`default_nettype none

package dma_int_pkg;

    // bus and counter widths.
    localparam int DATA_W = 32;
    localparam int ADDR_W = 3;
    localparam int LEN_W  = 16;

    // register indices, word addressed.
    localparam logic [ADDR_W-1:0] ADDR_CTRL    = 3'd0;
    localparam logic [ADDR_W-1:0] ADDR_RD_LEN  = 3'd1;
    localparam logic [ADDR_W-1:0] ADDR_WR_LEN  = 3'd2;
    localparam logic [ADDR_W-1:0] ADDR_STATUS  = 3'd3;
    localparam logic [ADDR_W-1:0] ADDR_INT_CNT = 3'd4;

    // ctrl word, start bits are write-one pulses.
    localparam int CTRL_EN       = 0;
    localparam int CTRL_INT_EN   = 1;
    localparam int CTRL_RD_MSK   = 2;
    localparam int CTRL_WR_MSK   = 3;
    localparam int CTRL_RD_START = 4;
    localparam int CTRL_WR_START = 5;

    // status word.
    localparam int STATUS_RD_DONE = 0;
    localparam int STATUS_WR_DONE = 1;
    localparam int STATUS_RD_BUSY = 2;
    localparam int STATUS_WR_BUSY = 3;

    // interrupt manager states, one-hot.
    localparam logic [1:0] INT_IDLE    = 2'b01;
    localparam logic [1:0] INT_PENDING = 2'b10;

endpackage

`default_nettype wire
